//--- boot_rom.hex
// One 32-bit ROM word per line, word 0 first
// Bits 23:16 hold the word index, bits 7:0 its complement in five bits
b000c31f
b001c31e
b002c31d
b003c31c
b004c31b
b005c31a
b006c319
b007c318
b008c317
b009c316
b00ac315
b00bc314
b00cc313
b00dc312
b00ec311
b00fc310
b010c30f
b011c30e
b012c30d
b013c30c
b014c30b
b015c30a
b016c309
b017c308
b018c307
b019c306
b01ac305
b01bc304
b01cc303
b01dc302
b01ec301
b01fc300

//--- files.f
periph_pkg.sv
wb_if.sv
wb_decoder.sv
boot_rom.sv
sys_con.sv
gpio_ctrl.sv
periph_top.sv
periph_checker.sv
tb_clock.sv
periph_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = periph_tb
FILELIST  = files.f
SOURCES   = $(shell grep -v '^+' $(FILELIST))
BIN       = obj_dir/V$(TOP)
PASS_MSG  = All tests passed

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+1000 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- periph_tb.sv
//****************************************
// Testbench for the peripheral top level
// Checks are done by the bound checker
//****************************************

module periph_tb;
   import periph_pkg::*;

   // About 300 cycles of traffic, with a wide margin
   localparam int TIMEOUT_CYCLES = 2000;

   logic       clk, i_reset, i_wb_we, i_wb_cyc, i_wb_stb, o_wb_ack;
   logic       o_timer_irq, o_gpio_irq;
   logic [1:0] o_sw_irq;
   wb_addr_t   i_wb_adr;
   wb_data_t   i_wb_dat, o_wb_rdt;
   gpio_t      i_gpio, o_gpio, o_gpio_oe;

   bind periph_top periph_checker u_checker (.*);

   tb_clock u_clock (.o_clk(clk));

   periph_top i_periph_top (.*);

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Some tests failed");
      $fatal(1, "run stopped");
   endtask

   function automatic wb_addr_t reg_addr(input region_t region, input reg_off_t off);
      return {region, 7'b0, off, 2'b00};
   endfunction

   // One request, held until ack
   task automatic bus_access(input wb_addr_t adr, input logic we, input wb_data_t dat,
                             output wb_data_t rdt);
      int waited;
      @(negedge clk);
      i_wb_adr = adr;
      i_wb_dat = dat;
      i_wb_we  = we;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      waited   = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!o_wb_ack && waited < 8);
      if (!o_wb_ack) begin
         stop_with_failure("bus request got no ack");
      end else begin
         rdt      = o_wb_rdt;
         i_wb_cyc = 1'b0;
         i_wb_stb = 1'b0;
         i_wb_we  = 1'b0;
      end
   endtask

   task automatic write_reg(input wb_addr_t adr, input wb_data_t dat);
      wb_data_t unused;
      bus_access(adr, 1'b1, dat, unused);
   endtask

   task automatic read_reg(input wb_addr_t adr);
      wb_data_t rdt;
      bus_access(adr, 1'b0, '0, rdt);
   endtask

   initial begin
      wait (i_periph_top.u_checker.failed);
      stop_with_failure("the checker reported an assertion failure");
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      stop_with_failure("watchdog timeout, the run did not finish");
   end

   initial begin
      int seed;
      seed     = 32'h6bc0308a;
      i_reset  = 1'b1;
      i_wb_adr = '0;
      i_wb_dat = '0;
      i_wb_we  = 1'b0;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_gpio   = '0;
      repeat (16) @(negedge clk);
      i_reset = 1'b0;

      // ROM, unmapped regions and version
      for (int k = 0; k < ROM_WORDS; k++) begin
         read_reg({REGION_ROM, 5'b0, rom_index_t'(k), 2'b00});
      end
      read_reg(16'h3000);
      read_reg(16'hf004);
      read_reg(reg_addr(REGION_SYSCON, SYSCON_VERSION_REG));

      // GPIO output, enable and interrupt enable
      write_reg(reg_addr(REGION_GPIO, GPIO_OUT_REG), 32'h0000_00a5);
      read_reg(reg_addr(REGION_GPIO, GPIO_OUT_REG));
      write_reg(reg_addr(REGION_GPIO, GPIO_OE_REG), 32'h0000_003c);
      read_reg(reg_addr(REGION_GPIO, GPIO_OE_REG));
      write_reg(reg_addr(REGION_GPIO, GPIO_IE_REG), 32'h0000_00ff);
      read_reg(reg_addr(REGION_GPIO, GPIO_IE_REG));

      // Input edges, random then one clean edge on bit 0
      repeat (20) begin
         @(negedge clk);
         i_gpio = gpio_t'($random(seed));
      end
      @(negedge clk);
      i_gpio = '0;
      write_reg(reg_addr(REGION_GPIO, GPIO_IS_REG), 32'h0000_00ff);
      repeat (4) @(negedge clk);
      i_gpio = 8'h01;
      repeat (5) @(negedge clk);
      write_reg(reg_addr(REGION_GPIO, GPIO_IS_REG), 32'h0000_0001);

      // Machine timer
      write_reg(reg_addr(REGION_SYSCON, SYSCON_MTIMECMP_REG), 32'h0000_0000);
      repeat (3) @(negedge clk);
      write_reg(reg_addr(REGION_SYSCON, SYSCON_MTIMECMP_REG), 32'hffff_ffff);
      read_reg(reg_addr(REGION_SYSCON, SYSCON_MTIME_REG));
      read_reg(reg_addr(REGION_SYSCON, SYSCON_MTIME_REG));

      // Software interrupts
      write_reg(reg_addr(REGION_SYSCON, SYSCON_SW_IRQ_REG), 32'h0000_0002);
      read_reg(reg_addr(REGION_SYSCON, SYSCON_SW_IRQ_REG));
      write_reg(reg_addr(REGION_SYSCON, SYSCON_SW_IRQ_REG), 32'h0000_0001);
      read_reg(reg_addr(REGION_SYSCON, SYSCON_SW_IRQ_REG));

      repeat (4) @(negedge clk);
      if (i_periph_top.u_checker.failed) begin
         stop_with_failure("an assertion failed during the run");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

//--- tb_clock.sv
//****************************************
// Testbench clock, period of 4 time units
//****************************************

module tb_clock (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever #2 o_clk = ~o_clk;
   end

endmodule

//--- periph_checker.sv
//****************************************
// Bus timing and register checks, bound to
// the peripheral top level
//****************************************

module periph_checker (
   input logic                 clk,
   input logic                 i_reset,
   input periph_pkg::wb_addr_t i_wb_adr,
   input periph_pkg::wb_data_t i_wb_dat,
   input logic                 i_wb_we,
   input logic                 i_wb_cyc,
   input logic                 i_wb_stb,
   input periph_pkg::wb_data_t o_wb_rdt,
   input logic                 o_wb_ack,
   input periph_pkg::gpio_t    i_gpio,
   input periph_pkg::gpio_t    o_gpio,
   input periph_pkg::gpio_t    o_gpio_oe,
   input logic                 o_timer_irq,
   input logic [1:0]           o_sw_irq,
   input logic                 o_gpio_irq
);
   import periph_pkg::*;

   wb_data_t   rom_m [ROM_WORDS];
   logic       busy, new_req, wr_req, cap_we, have_mtime, exp_valid, mtime_rd;
   wb_addr_t   cap_adr;
   wb_data_t   cap_dat, exp_rdt, last_mtime;
   region_t    req_region, cap_region;
   reg_off_t   req_off, cap_off;
   gpio_t      out_m, oe_m, ie_m, is_m, clr_m, in_d1, in_d2, in_d3;
   logic [1:0] sw_m;
   logic       f_ack = 1'b0, f_once = 1'b0, f_spur = 1'b0, f_rdt = 1'b0;
   logic       f_out = 1'b0, f_irq = 1'b0, f_timer = 1'b0, f_mtime = 1'b0;
   logic       failed;

   initial begin
      $readmemh(ROM_INIT_FILE, rom_m);
   end

   assign new_req    = i_wb_cyc & i_wb_stb & ~busy;
   assign wr_req     = new_req & i_wb_we;
   assign req_region = i_wb_adr[15:12];
   assign req_off    = i_wb_adr[4:2];
   assign cap_region = cap_adr[15:12];
   assign cap_off    = cap_adr[4:2];
   assign mtime_rd   = ~cap_we && cap_region == REGION_SYSCON && cap_off == SYSCON_MTIME_REG;
   assign clr_m      = (wr_req && req_region == REGION_GPIO && req_off == GPIO_IS_REG) ?
                       i_wb_dat[GPIO_WIDTH-1:0] : '0;
   assign failed     = f_ack | f_once | f_spur | f_rdt | f_out | f_irq | f_timer | f_mtime;

   //****************************************
   // Reference model of the registers
   //****************************************
   always_ff @(posedge clk) begin
      in_d1 <= i_gpio;
      in_d2 <= in_d1;
      in_d3 <= in_d2;
      if (new_req) begin
         cap_adr <= i_wb_adr;
         cap_dat <= i_wb_dat;
         cap_we  <= i_wb_we;
      end
      if (i_reset) begin
         busy       <= 1'b0;
         {out_m, oe_m, ie_m, is_m} <= '0;
         sw_m       <= 2'b00;
         have_mtime <= 1'b0;
      end else begin
         busy <= new_req | (busy & ~o_wb_ack);
         if (wr_req && req_region == REGION_GPIO && req_off == GPIO_OUT_REG)
            out_m <= i_wb_dat[GPIO_WIDTH-1:0];
         if (wr_req && req_region == REGION_GPIO && req_off == GPIO_OE_REG)
            oe_m <= i_wb_dat[GPIO_WIDTH-1:0];
         if (wr_req && req_region == REGION_GPIO && req_off == GPIO_IE_REG)
            ie_m <= i_wb_dat[GPIO_WIDTH-1:0];
         if (wr_req && req_region == REGION_SYSCON && req_off == SYSCON_SW_IRQ_REG)
            sw_m <= i_wb_dat[1:0];
         // Rising edge after two sync stages
         is_m <= (is_m & ~clr_m) | (in_d2 & ~in_d3);
         if (o_wb_ack && mtime_rd) begin
            last_mtime <= o_wb_rdt;
            have_mtime <= 1'b1;
         end
      end
   end

   always_comb begin
      exp_valid = 1'b1;
      exp_rdt   = '0;
      case (cap_region)
         REGION_ROM:    exp_rdt = rom_m[cap_adr[6:2]];
         REGION_SYSCON: begin
            exp_valid = (cap_off == SYSCON_VERSION_REG) || (cap_off == SYSCON_SW_IRQ_REG);
            exp_rdt   = (cap_off == SYSCON_VERSION_REG) ? SYSCON_VERSION : wb_data_t'(sw_m);
         end
         REGION_GPIO: begin
            exp_valid = (cap_off == GPIO_OUT_REG) || (cap_off == GPIO_OE_REG) ||
                        (cap_off == GPIO_IE_REG);
            exp_rdt   = (cap_off == GPIO_OUT_REG) ? wb_data_t'(out_m) :
                        (cap_off == GPIO_OE_REG)  ? wb_data_t'(oe_m)  : wb_data_t'(ie_m);
         end
         default:       exp_rdt = '0;
      endcase
   end

   //****************************************
   // Assertions
   //****************************************
   assert property (@(posedge clk) disable iff (i_reset) new_req |=> o_wb_ack)
      else begin $error("no ack one cycle after a request at t=%0t", $time); f_ack = 1'b1; end
   assert property (@(posedge clk) disable iff (i_reset) o_wb_ack |=> !o_wb_ack)
      else begin $error("ack held longer than one cycle at t=%0t", $time); f_once = 1'b1; end
   assert property (@(posedge clk) o_wb_ack |-> !$past(i_reset) && $past(new_req))
      else begin $error("ack without a request at t=%0t", $time); f_spur = 1'b1; end
   assert property (@(posedge clk) disable iff (i_reset)
                    o_wb_ack && !cap_we && exp_valid |-> o_wb_rdt == exp_rdt)
      else begin
         $error("error t=%0t o_wb_rdt got %h expected %h", $time, $sampled(o_wb_rdt),
                $sampled(exp_rdt));
         f_rdt = 1'b1;
      end
   assert property (@(posedge clk) disable iff (i_reset)
                    o_gpio == out_m && o_gpio_oe == oe_m && o_sw_irq == sw_m)
      else begin
         $error("error t=%0t o_gpio/o_gpio_oe/o_sw_irq got %h/%h/%h expected %h/%h/%h",
                $time, $sampled(o_gpio), $sampled(o_gpio_oe), $sampled(o_sw_irq),
                $sampled(out_m), $sampled(oe_m), $sampled(sw_m));
         f_out = 1'b1;
      end
   assert property (@(posedge clk) disable iff (i_reset) o_gpio_irq == |(is_m & ie_m))
      else begin
         $error("error t=%0t o_gpio_irq got %b expected %b", $time, $sampled(o_gpio_irq),
                $sampled(|(is_m & ie_m)));
         f_irq = 1'b1;
      end
   assert property (@(posedge clk) disable iff (i_reset)
                    o_wb_ack && cap_we && cap_region == REGION_SYSCON &&
                    cap_off == SYSCON_MTIMECMP_REG && (cap_dat == '0 || cap_dat == '1)
                    |=> o_timer_irq == $past(cap_dat == '0))
      else begin
         $error("error t=%0t o_timer_irq got %b expected %b", $time, $sampled(o_timer_irq),
                $sampled(cap_dat == '0));
         f_timer = 1'b1;
      end
   assert property (@(posedge clk) disable iff (i_reset)
                    o_wb_ack && mtime_rd && have_mtime |-> o_wb_rdt > last_mtime)
      else begin
         $error("error t=%0t mtime got %h expected above %h", $time, $sampled(o_wb_rdt),
                $sampled(last_mtime));
         f_mtime = 1'b1;
      end

endmodule

//--- periph_top.sv
//****************************************
// Peripheral subsystem top level, driven
// by one external Wishbone master
//****************************************

module periph_top (
   input  logic                 clk,
   input  logic                 i_reset,
   input  periph_pkg::wb_addr_t i_wb_adr,
   input  periph_pkg::wb_data_t i_wb_dat,
   input  logic                 i_wb_we,
   input  logic                 i_wb_cyc,
   input  logic                 i_wb_stb,
   output periph_pkg::wb_data_t o_wb_rdt,
   output logic                 o_wb_ack,
   input  periph_pkg::gpio_t    i_gpio,
   output periph_pkg::gpio_t    o_gpio,
   output periph_pkg::gpio_t    o_gpio_oe,
   output logic                 o_timer_irq,
   output logic [1:0]           o_sw_irq,
   output logic                 o_gpio_irq
);

   wb_if rom_bus ();
   wb_if sys_bus ();
   wb_if gpio_bus ();

   wb_decoder u_decoder (
      .clk      (clk),
      .i_reset  (i_reset),
      .i_adr    (i_wb_adr),
      .i_dat    (i_wb_dat),
      .i_we     (i_wb_we),
      .i_cyc    (i_wb_cyc),
      .i_stb    (i_wb_stb),
      .o_rdt    (o_wb_rdt),
      .o_ack    (o_wb_ack),
      .rom_bus  (rom_bus),
      .sys_bus  (sys_bus),
      .gpio_bus (gpio_bus)
   );

   boot_rom u_boot_rom (
      .clk     (clk),
      .i_reset (i_reset),
      .bus     (rom_bus)
   );

   sys_con u_sys_con (
      .clk         (clk),
      .i_reset     (i_reset),
      .bus         (sys_bus),
      .o_timer_irq (o_timer_irq),
      .o_sw_irq    (o_sw_irq)
   );

   gpio_ctrl u_gpio_ctrl (
      .clk       (clk),
      .i_reset   (i_reset),
      .bus       (gpio_bus),
      .i_gpio    (i_gpio),
      .o_gpio    (o_gpio),
      .o_gpio_oe (o_gpio_oe),
      .o_irq     (o_gpio_irq)
   );

endmodule

//--- gpio_ctrl.sv
//****************************************
// GPIO block with output, enable and
// rising-edge interrupt registers
//****************************************

module gpio_ctrl (
   input  logic              clk,
   input  logic              i_reset,
   wb_if.slave               bus,
   input  periph_pkg::gpio_t i_gpio,
   output periph_pkg::gpio_t o_gpio,
   output periph_pkg::gpio_t o_gpio_oe,
   output logic              o_irq
);
   import periph_pkg::*;

   reg_off_t offset;
   logic     req;
   logic     wr;
   gpio_t    sync1;
   gpio_t    sync2;
   gpio_t    prev;
   gpio_t    rise;
   gpio_t    clr;
   gpio_t    ie_r;
   gpio_t    is_r;

   assign offset = bus.adr[4:2];
   assign req    = bus.cyc & bus.stb & ~bus.ack;
   assign wr     = req & bus.we;

   //****************************************
   // Input synchroniser and edge detect
   //****************************************
   always_ff @(posedge clk) begin
      sync1 <= i_gpio;
      sync2 <= sync1;
      prev  <= sync2;
   end

   assign rise = sync2 & ~prev;
   assign clr  = (wr && offset == GPIO_IS_REG) ? bus.dat[GPIO_WIDTH-1:0] : '0;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_gpio    <= '0;
         o_gpio_oe <= '0;
         ie_r      <= '0;
         is_r      <= '0;
      end else begin
         if (wr && offset == GPIO_OUT_REG) begin
            o_gpio <= bus.dat[GPIO_WIDTH-1:0];
         end
         if (wr && offset == GPIO_OE_REG) begin
            o_gpio_oe <= bus.dat[GPIO_WIDTH-1:0];
         end
         if (wr && offset == GPIO_IE_REG) begin
            ie_r <= bus.dat[GPIO_WIDTH-1:0];
         end
         // A new edge wins over a clear
         is_r <= (is_r & ~clr) | rise;
      end
   end

   assign o_irq = |(is_r & ie_r);

   //****************************************
   // Bus response
   //****************************************
   always_ff @(posedge clk) begin
      case (offset)
         GPIO_IN_REG:  bus.rdt <= wb_data_t'(sync2);
         GPIO_OUT_REG: bus.rdt <= wb_data_t'(o_gpio);
         GPIO_OE_REG:  bus.rdt <= wb_data_t'(o_gpio_oe);
         GPIO_IE_REG:  bus.rdt <= wb_data_t'(ie_r);
         GPIO_IS_REG:  bus.rdt <= wb_data_t'(is_r);
         default:      bus.rdt <= '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= req;
      end
   end

endmodule

//--- sys_con.sv
//****************************************
// System controller with version word,
// software interrupts and the machine timer
//****************************************

module sys_con (
   input  logic       clk,
   input  logic       i_reset,
   wb_if.slave        bus,
   output logic       o_timer_irq,
   output logic [1:0] o_sw_irq
);
   import periph_pkg::*;

   reg_off_t offset;
   logic     req;
   logic     wr;
   wb_data_t mtime;
   wb_data_t mtimecmp;

   assign offset = bus.adr[4:2];
   assign req    = bus.cyc & bus.stb & ~bus.ack;
   assign wr     = req & bus.we;

   //****************************************
   // Register writes
   //****************************************
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_sw_irq <= 2'b00;
         mtime    <= '0;
         mtimecmp <= '1;
      end else begin
         if (wr && offset == SYSCON_SW_IRQ_REG) begin
            o_sw_irq <= bus.dat[1:0];
         end
         if (wr && offset == SYSCON_MTIME_REG) begin
            mtime <= bus.dat;
         end else begin
            mtime <= mtime + 1'b1;
         end
         if (wr && offset == SYSCON_MTIMECMP_REG) begin
            mtimecmp <= bus.dat;
         end
      end
   end

   // Timer interrupt, one cycle behind the compare
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_timer_irq <= 1'b0;
      end else begin
         o_timer_irq <= (mtime >= mtimecmp);
      end
   end

   //****************************************
   // Bus response
   //****************************************
   always_ff @(posedge clk) begin
      case (offset)
         SYSCON_VERSION_REG:  bus.rdt <= SYSCON_VERSION;
         SYSCON_SW_IRQ_REG:   bus.rdt <= wb_data_t'(o_sw_irq);
         SYSCON_MTIME_REG:    bus.rdt <= mtime;
         SYSCON_MTIMECMP_REG: bus.rdt <= mtimecmp;
         default:             bus.rdt <= '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= req;
      end
   end

endmodule

//--- boot_rom.sv
//****************************************
// Boot ROM, filled from a hex file
// Writes are acked and dropped
//****************************************

module boot_rom (
   input logic clk,
   input logic i_reset,
   wb_if.slave bus
);
   import periph_pkg::*;

   wb_data_t   rom [ROM_WORDS];
   rom_index_t index;

   initial begin
      $readmemh(ROM_INIT_FILE, rom);
   end

   // Word address
   assign index = bus.adr[6:2];

   always_ff @(posedge clk) begin
      bus.rdt <= rom[index];
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.cyc & bus.stb & ~bus.ack;
      end
   end

endmodule

//--- wb_decoder.sv
//****************************************
// Routes the bus master to the ROM, system
// controller or GPIO by address region
//****************************************

module wb_decoder (
   input  logic                 clk,
   input  logic                 i_reset,
   input  periph_pkg::wb_addr_t i_adr,
   input  periph_pkg::wb_data_t i_dat,
   input  logic                 i_we,
   input  logic                 i_cyc,
   input  logic                 i_stb,
   output periph_pkg::wb_data_t o_rdt,
   output logic                 o_ack,
   wb_if.master                 rom_bus,
   wb_if.master                 sys_bus,
   wb_if.master                 gpio_bus
);
   import periph_pkg::*;

   region_t region;
   logic    sel_rom;
   logic    sel_sys;
   logic    sel_gpio;
   logic    sel_none;
   logic    none_ack;

   assign region   = i_adr[15:12];
   assign sel_rom  = (region == REGION_ROM);
   assign sel_sys  = (region == REGION_SYSCON);
   assign sel_gpio = (region == REGION_GPIO);
   assign sel_none = ~(sel_rom | sel_sys | sel_gpio);

   // Address, data and we fan out, only cyc and stb are steered
   assign rom_bus.adr  = i_adr;
   assign rom_bus.dat  = i_dat;
   assign rom_bus.we   = i_we;
   assign rom_bus.cyc  = i_cyc & sel_rom;
   assign rom_bus.stb  = i_stb & sel_rom;

   assign sys_bus.adr  = i_adr;
   assign sys_bus.dat  = i_dat;
   assign sys_bus.we   = i_we;
   assign sys_bus.cyc  = i_cyc & sel_sys;
   assign sys_bus.stb  = i_stb & sel_sys;

   assign gpio_bus.adr = i_adr;
   assign gpio_bus.dat = i_dat;
   assign gpio_bus.we  = i_we;
   assign gpio_bus.cyc = i_cyc & sel_gpio;
   assign gpio_bus.stb = i_stb & sel_gpio;

   // Unmapped regions still get a single ack
   always_ff @(posedge clk) begin
      if (i_reset) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= i_cyc & i_stb & sel_none & ~none_ack;
      end
   end

   always_comb begin
      case (region)
         REGION_ROM: begin
            o_rdt = rom_bus.rdt;
            o_ack = rom_bus.ack;
         end
         REGION_SYSCON: begin
            o_rdt = sys_bus.rdt;
            o_ack = sys_bus.ack;
         end
         REGION_GPIO: begin
            o_rdt = gpio_bus.rdt;
            o_ack = gpio_bus.ack;
         end
         default: begin
            o_rdt = '0;
            o_ack = none_ack;
         end
      endcase
   end

endmodule

//--- wb_if.sv
//****************************************
// Single-word Wishbone link between the
// address decoder and one slave
//****************************************

interface wb_if;

   periph_pkg::wb_addr_t adr;
   periph_pkg::wb_data_t dat;
   logic                 we;
   logic                 cyc;
   logic                 stb;
   periph_pkg::wb_data_t rdt;
   logic                 ack;

   modport master (
      output adr, dat, we, cyc, stb,
      input  rdt, ack
   );

   modport slave (
      input  adr, dat, we, cyc, stb,
      output rdt, ack
   );

endinterface

//--- periph_pkg.sv
//****************************************
// Shared types, address map and register
// offsets for the peripheral bus and its slaves
//****************************************

package periph_pkg;

   //****************************************
   // Bus types
   //****************************************
   typedef logic [15:0] wb_addr_t;
   typedef logic [31:0] wb_data_t;

   // Address bits 15 to 12 pick the region, bits 4 to 2 the register
   typedef logic [3:0] region_t;
   typedef logic [2:0] reg_off_t;

   //****************************************
   // Address map
   //****************************************
   localparam region_t REGION_ROM    = 4'd0;
   localparam region_t REGION_SYSCON = 4'd1;
   localparam region_t REGION_GPIO   = 4'd2;

   // Boot ROM
   localparam int ROM_WORDS = 32;
   typedef logic [4:0] rom_index_t;
   localparam string ROM_INIT_FILE = "boot_rom.hex";

   // System controller
   localparam wb_data_t SYSCON_VERSION = 32'h0001_0300;

   localparam reg_off_t SYSCON_VERSION_REG  = 3'd0;
   localparam reg_off_t SYSCON_SW_IRQ_REG   = 3'd1;
   localparam reg_off_t SYSCON_MTIME_REG    = 3'd2;
   localparam reg_off_t SYSCON_MTIMECMP_REG = 3'd3;

   // GPIO
   localparam int GPIO_WIDTH = 8;
   typedef logic [GPIO_WIDTH-1:0] gpio_t;

   localparam reg_off_t GPIO_IN_REG  = 3'd0;
   localparam reg_off_t GPIO_OUT_REG = 3'd1;
   localparam reg_off_t GPIO_OE_REG  = 3'd2;
   localparam reg_off_t GPIO_IE_REG  = 3'd3;
   localparam reg_off_t GPIO_IS_REG  = 3'd4;

endpackage
